//--- sources.f
rtl/acc_cmd_pkg.sv
rtl/acc_fsm_pkg.sv
rtl/task_dispatch.sv
rtl/conv_sequencer.sv
rtl/pass_sequencer.sv
rtl/acc_sequencer_top.sv
test/tb_acc_sequencer.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the sequencer regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f sources.f \
	--top-module tb_acc_sequencer -Mdir obj_dir -o tb_acc_sequencer
status=$?
if [ "$status" -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_acc_sequencer)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1

//--- test/tb_acc_sequencer.sv
`default_nettype none

module tb_acc_sequencer import acc_cmd_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLK_PERIOD       = 40;
	localparam int RESET_CYCLES     = 8;
	localparam int CYCLES_PER_PULSE = 40;
	localparam int STALL_CYCLES     = 30;
	localparam int IDLE_CYCLES      = 10;

	// expected pulses per test including datapath replies
	localparam int PULSES_RESET   = 4;
	localparam int PULSES_CONV    = 42;	// 2 in x 3 out
	localparam int PULSES_ADD     = 9;
	localparam int PULSES_POOL    = 18;
	localparam int PULSES_UPS     = 15;
	localparam int PULSES_RESTART = 25;
	localparam int WATCH_CYCLES   = RESET_CYCLES + CYCLES_PER_PULSE *
		(PULSES_RESET + PULSES_CONV + PULSES_ADD + PULSES_POOL + PULSES_UPS + PULSES_RESTART);

	// strobe tally slots
	localparam logic [3:0] ST_LOAD    = 4'd0;
	localparam logic [3:0] ST_COMPUTE = 4'd1;
	localparam logic [3:0] ST_RET_REQ = 4'd2;
	localparam logic [3:0] ST_REFRESH = 4'd3;
	localparam logic [3:0] ST_FREE    = 4'd4;
	localparam logic [3:0] ST_FIRST   = 4'd5;
	localparam logic [3:0] ST_NEXT    = 4'd6;
	localparam logic [3:0] ST_DIRECT  = 4'd7;	// return_req with direct_out high
	localparam logic [3:0] ST_BIAS    = 4'd8;	// change code with bias_or_adder_feature high

	logic       system_clk;
	logic       rst_n;
	logic       task_start;
	logic       task_finish;
	logic       calculate_start;
	order_t     order;
	patch_cnt_t in_patch_num;
	patch_cnt_t out_patch_num;
	logic       weight_and_bias_ready;
	logic       compute_finish;
	logic       return_finish;
	logic       upsample_buffer_empty;
	logic       calculate_finish;
	wb_change_t change_weight_bias;
	logic       load_feature_begin;
	logic       compute_begin;
	logic       return_req;
	logic       refresh_return_addr;
	logic       free_feature_read_addr;
	logic       output_buffer_done;
	logic       direct_out;
	logic       bias_or_adder_feature;
	ret_sel_t   return_select;
	kern_t      kernel_size;

	int unsigned pulses [9] = '{default: 0};
	int unsigned base [9] = '{default: 0};
	int          n_tests  = 0;
	int          n_checks = 0;
	int          n_errors = 0;

	acc_sequencer_top dut0 (
		.system_clk             (system_clk),
		.rst_n                  (rst_n),
		.task_start             (task_start),
		.task_finish            (task_finish),
		.calculate_start        (calculate_start),
		.order                  (order),
		.in_patch_num           (in_patch_num),
		.out_patch_num          (out_patch_num),
		.weight_and_bias_ready  (weight_and_bias_ready),
		.compute_finish         (compute_finish),
		.return_finish          (return_finish),
		.upsample_buffer_empty  (upsample_buffer_empty),
		.calculate_finish       (calculate_finish),
		.change_weight_bias     (change_weight_bias),
		.load_feature_begin     (load_feature_begin),
		.compute_begin          (compute_begin),
		.return_req             (return_req),
		.refresh_return_addr    (refresh_return_addr),
		.free_feature_read_addr (free_feature_read_addr),
		.output_buffer_done     (output_buffer_done),
		.direct_out             (direct_out),
		.bias_or_adder_feature  (bias_or_adder_feature),
		.return_select          (return_select),
		.kernel_size            (kernel_size)
	);

	initial begin : clock_gen
		system_clk = 1'b0;
		forever #(CLK_PERIOD / 2) system_clk = ~system_clk;
	end

	// datapath stand-in for the weight loader
	initial begin : weight_responder
		int unsigned gap;
		weight_and_bias_ready = 1'b0;
		forever begin
			@(negedge system_clk);
			if (change_weight_bias != '0) begin
				gap = ($urandom % 4) + 1;
				repeat (gap) @(negedge system_clk);
				weight_and_bias_ready = 1'b1;
				@(negedge system_clk);
				weight_and_bias_ready = 1'b0;
			end
		end
	end

	initial begin : compute_responder
		int unsigned gap;
		compute_finish = 1'b0;
		forever begin
			@(negedge system_clk);
			if (compute_begin) begin
				gap = ($urandom % 4) + 1;
				repeat (gap) @(negedge system_clk);
				compute_finish = 1'b1;
				@(negedge system_clk);
				compute_finish = 1'b0;
			end
		end
	end

	initial begin : return_responder
		int unsigned gap;
		return_finish = 1'b0;
		forever begin
			@(negedge system_clk);
			if (output_buffer_done) begin
				gap = ($urandom % 4) + 1;
				repeat (gap) @(negedge system_clk);
				return_finish = 1'b1;
				@(negedge system_clk);
				return_finish = 1'b0;
			end
		end
	end

	initial begin : strobe_counter
		forever begin
			@(negedge system_clk);
			if (load_feature_begin) pulses[ST_LOAD]++;
			if (compute_begin) pulses[ST_COMPUTE]++;
			if (return_req) pulses[ST_RET_REQ]++;
			if (refresh_return_addr) pulses[ST_REFRESH]++;
			if (free_feature_read_addr) pulses[ST_FREE]++;
			if (change_weight_bias == WB_FIRST) pulses[ST_FIRST]++;
			if (change_weight_bias == WB_NEXT) pulses[ST_NEXT]++;
			if (return_req && direct_out) pulses[ST_DIRECT]++;
			if ((change_weight_bias != '0) && bias_or_adder_feature) pulses[ST_BIAS]++;
		end
	end

	initial begin : watchdog
		#(WATCH_CYCLES * CLK_PERIOD);
		$display("timeout: run still going after %0d cycles", WATCH_CYCLES);
		$display("Regression failed");
		$finish;
	end

	task automatic check_cnt(input string name, input patch_cnt_t got, input patch_cnt_t want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, want);
		end
	endtask

	task automatic check_sel(input string name, input ret_sel_t got, input ret_sel_t want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, want);
		end
	endtask

	task automatic check_kern(input string name, input kern_t got, input kern_t want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, want);
		end
	endtask

	task automatic check_wb(input string name, input wb_change_t got, input wb_change_t want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, want);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, want);
		end
	endtask

	function automatic patch_cnt_t count_since(input logic [3:0] idx);
		return patch_cnt_t'(pulses[idx] - base[idx]);
	endfunction

	task automatic mark_counts();
		base = pulses;
	endtask

	task automatic report_test(input string name, input int errs_before);
		n_tests++;
		if (n_errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, n_errors - errs_before);
		end
	endtask

	task automatic pulse_task_start();
		task_start = 1'b1;
		@(negedge system_clk);
		task_start = 1'b0;
	endtask

	// returns on the falling edge after the order was sampled
	task automatic issue_order(input order_t code, input patch_cnt_t n_in, input patch_cnt_t n_out);
		order           = code;
		in_patch_num    = n_in;
		out_patch_num   = n_out;
		calculate_start = 1'b1;
		@(negedge system_clk);
		calculate_start = 1'b0;
	endtask

	task automatic wait_finish(input int limit);
		int cycles;
		cycles = 0;
		n_checks++;
		while (!calculate_finish && cycles < limit) begin
			@(negedge system_clk);
			cycles++;
		end
		if (!calculate_finish) begin
			n_errors++;
			$display("order did not finish within %0d cycles", limit);
		end
		@(negedge system_clk);
	endtask

	task automatic conv_body(input patch_cnt_t n_in, input patch_cnt_t n_out, input int budget);
		mark_counts();
		issue_order(ORDER_CONV, n_in, n_out);
		check_bit("calculate_finish", calculate_finish, 1'b0);
		check_sel("return_select", return_select, 4'b0001);
		check_kern("kernel_size", kernel_size, 3'd3);
		wait_finish(CYCLES_PER_PULSE * budget);
		check_cnt("load_feature_begin count", count_since(ST_LOAD), n_in * n_out);
		check_cnt("compute_begin count", count_since(ST_COMPUTE), n_in * n_out);
		check_cnt("WB_FIRST count", count_since(ST_FIRST), n_out);
		check_cnt("WB_NEXT count", count_since(ST_NEXT), n_out * (n_in - 8'd1));
		check_cnt("bias_or_adder_feature at change code", count_since(ST_BIAS), n_out);
		check_cnt("return_req count", count_since(ST_RET_REQ), n_out);
		check_cnt("direct_out at return_req", count_since(ST_DIRECT), n_out);
		check_cnt("refresh_return_addr count", count_since(ST_REFRESH), 8'd1);
		check_cnt("free_feature_read_addr count", count_since(ST_FREE), n_out);
		check_bit("direct_out", direct_out, 1'b0);
		check_sel("return_select", return_select, 4'b0000);
	endtask

	task automatic test_reset_state();
		int errs;
		errs = n_errors;
		check_bit("calculate_finish", calculate_finish, 1'b1);
		check_bit("load_feature_begin", load_feature_begin, 1'b0);
		check_bit("compute_begin", compute_begin, 1'b0);
		check_bit("return_req", return_req, 1'b0);
		check_bit("refresh_return_addr", refresh_return_addr, 1'b0);
		check_bit("free_feature_read_addr", free_feature_read_addr, 1'b0);
		check_bit("output_buffer_done", output_buffer_done, 1'b0);
		check_bit("direct_out", direct_out, 1'b0);
		check_bit("bias_or_adder_feature", bias_or_adder_feature, 1'b1);
		check_wb("change_weight_bias", change_weight_bias, 2'b00);
		check_sel("return_select", return_select, 4'b0000);
		pulse_task_start();
		mark_counts();
		issue_order(3'd6, 8'd1, 8'd1);	// no such order
		repeat (IDLE_CYCLES) begin
			@(negedge system_clk);
			check_bit("calculate_finish", calculate_finish, 1'b1);
		end
		check_cnt("compute_begin count", count_since(ST_COMPUTE), 8'd0);
		report_test("reset and unknown order", errs);
	endtask

	task automatic test_conv();
		int errs;
		errs = n_errors;
		conv_body(8'd2, 8'd3, PULSES_CONV);
		report_test("convolution 2 in 3 out", errs);
	endtask

	task automatic test_pass(input order_t code, input patch_cnt_t n_in, input patch_cnt_t n_runs,
		input ret_sel_t sel, input kern_t kern, input string name, input int budget);
		int errs;
		errs = n_errors;
		mark_counts();
		issue_order(code, n_in, 8'd0);
		check_bit("calculate_finish", calculate_finish, 1'b0);
		check_sel("return_select", return_select, sel);
		check_kern("kernel_size", kernel_size, kern);
		wait_finish(CYCLES_PER_PULSE * budget);
		check_cnt("load_feature_begin count", count_since(ST_LOAD), n_runs);
		check_cnt("compute_begin count", count_since(ST_COMPUTE), n_runs);
		check_cnt("return_req count", count_since(ST_RET_REQ), n_runs);
		check_cnt("refresh_return_addr count", count_since(ST_REFRESH), 8'd1);
		check_cnt("free_feature_read_addr count", count_since(ST_FREE), 8'd1);
		check_cnt("WB_FIRST count", count_since(ST_FIRST), 8'd0);
		report_test(name, errs);
	endtask

	task automatic test_upsample();
		int errs;
		errs = n_errors;
		mark_counts();
		upsample_buffer_empty = 1'b0;
		issue_order(ORDER_UPSAMPLE, 8'd2, 8'd0);
		check_sel("return_select", return_select, 4'b1000);
		check_kern("kernel_size", kernel_size, 3'd3);
		// buffer full so the return must stall
		repeat (STALL_CYCLES) begin
			@(negedge system_clk);
			check_bit("output_buffer_done", output_buffer_done, 1'b0);
			check_bit("calculate_finish", calculate_finish, 1'b0);
		end
		check_cnt("compute_begin count", count_since(ST_COMPUTE), 8'd1);
		upsample_buffer_empty = 1'b1;
		wait_finish(CYCLES_PER_PULSE * PULSES_UPS);
		check_cnt("compute_begin count", count_since(ST_COMPUTE), 8'd2);
		check_cnt("return_req count", count_since(ST_RET_REQ), 8'd2);
		check_cnt("refresh_return_addr count", count_since(ST_REFRESH), 8'd1);
		check_cnt("free_feature_read_addr count", count_since(ST_FREE), 8'd1);
		upsample_buffer_empty = 1'b0;
		report_test("upsample with buffer stall", errs);
	endtask

	task automatic test_task_restart();
		int errs;
		errs = n_errors;
		task_finish = 1'b1;
		@(negedge system_clk);
		task_finish = 1'b0;
		mark_counts();
		issue_order(ORDER_CONV, 8'd1, 8'd1);	// idle ignores it
		repeat (IDLE_CYCLES) begin
			@(negedge system_clk);
			check_bit("calculate_finish", calculate_finish, 1'b1);
		end
		check_cnt("compute_begin count", count_since(ST_COMPUTE), 8'd0);
		pulse_task_start();
		conv_body(8'd1, 8'd2, PULSES_RESTART);
		report_test("task finish then restart", errs);
	endtask

	initial begin : main_seq
		void'($urandom(9));
		rst_n                 = 1'b0;
		task_start            = 1'b0;
		task_finish           = 1'b0;
		calculate_start       = 1'b0;
		order                 = '0;
		in_patch_num          = '0;
		out_patch_num         = '0;
		upsample_buffer_empty = 1'b0;
		repeat (RESET_CYCLES) @(negedge system_clk);
		rst_n = 1'b1;
		@(negedge system_clk);
		test_reset_state();
		test_conv();
		test_pass(ORDER_ADD, 8'd2, 8'd1, 4'b0010, 3'd3, "add single pass", PULSES_ADD);
		test_pass(ORDER_POOL, 8'd3, 8'd3, 4'b0100, 3'd5, "pool 3 patches", PULSES_POOL);
		test_upsample();
		test_task_restart();
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/acc_sequencer_top.sv
`default_nettype none

module acc_sequencer_top import acc_cmd_pkg::*; (
	input  logic       system_clk,
	input  logic       rst_n,
	input  logic       task_start,
	input  logic       task_finish,
	input  logic       calculate_start,
	input  order_t     order,
	input  patch_cnt_t in_patch_num,
	input  patch_cnt_t out_patch_num,
	input  logic       weight_and_bias_ready,
	input  logic       compute_finish,
	input  logic       return_finish,
	input  logic       upsample_buffer_empty,
	output logic       calculate_finish,
	output wb_change_t change_weight_bias,
	output logic       load_feature_begin,
	output logic       compute_begin,
	output logic       return_req,
	output logic       refresh_return_addr,
	output logic       free_feature_read_addr,
	output logic       output_buffer_done,
	output logic       direct_out,
	output logic       bias_or_adder_feature,
	output ret_sel_t   return_select,
	output kern_t      kernel_size
);

	logic       conv_go;
	logic       pass_go;
	logic       conv_done;
	logic       pass_done;
	order_t     pass_order;
	patch_cnt_t in_patches;
	patch_cnt_t out_patches;

	// strobes from the convolution side
	wb_change_t conv_change_weight_bias;
	logic       conv_load_feature_begin;
	logic       conv_return_req;
	logic       conv_refresh_return_addr;
	logic       conv_compute_begin;
	logic       conv_free_feature_read_addr;
	logic       conv_output_buffer_done;

	// strobes from add / pool / upsample
	logic       pass_load_feature_begin;
	logic       pass_return_req;
	logic       pass_refresh_return_addr;
	logic       pass_compute_begin;
	logic       pass_free_feature_read_addr;
	logic       pass_output_buffer_done;

	task_dispatch u_task_dispatch (
		.system_clk                  (system_clk),
		.rst_n                       (rst_n),
		.task_start                  (task_start),
		.task_finish                 (task_finish),
		.calculate_start             (calculate_start),
		.order                       (order),
		.in_patch_num                (in_patch_num),
		.out_patch_num               (out_patch_num),
		.conv_done                   (conv_done),
		.pass_done                   (pass_done),
		.conv_change_weight_bias     (conv_change_weight_bias),
		.conv_load_feature_begin     (conv_load_feature_begin),
		.conv_return_req             (conv_return_req),
		.conv_refresh_return_addr    (conv_refresh_return_addr),
		.conv_compute_begin          (conv_compute_begin),
		.conv_free_feature_read_addr (conv_free_feature_read_addr),
		.conv_output_buffer_done     (conv_output_buffer_done),
		.pass_load_feature_begin     (pass_load_feature_begin),
		.pass_return_req             (pass_return_req),
		.pass_refresh_return_addr    (pass_refresh_return_addr),
		.pass_compute_begin          (pass_compute_begin),
		.pass_free_feature_read_addr (pass_free_feature_read_addr),
		.pass_output_buffer_done     (pass_output_buffer_done),
		.calculate_finish            (calculate_finish),
		.conv_go                     (conv_go),
		.pass_go                     (pass_go),
		.pass_order                  (pass_order),
		.in_patches                  (in_patches),
		.out_patches                 (out_patches),
		.change_weight_bias          (change_weight_bias),
		.load_feature_begin          (load_feature_begin),
		.return_req                  (return_req),
		.refresh_return_addr         (refresh_return_addr),
		.compute_begin               (compute_begin),
		.free_feature_read_addr      (free_feature_read_addr),
		.output_buffer_done          (output_buffer_done),
		.return_select               (return_select),
		.kernel_size                 (kernel_size)
	);

	conv_sequencer u_conv_sequencer (
		.system_clk             (system_clk),
		.rst_n                  (rst_n),
		.conv_go                (conv_go),
		.in_patches             (in_patches),
		.out_patches            (out_patches),
		.weight_and_bias_ready  (weight_and_bias_ready),
		.compute_finish         (compute_finish),
		.return_finish          (return_finish),
		.conv_done              (conv_done),
		.change_weight_bias     (conv_change_weight_bias),
		.direct_out             (direct_out),
		.bias_or_adder_feature  (bias_or_adder_feature),
		.load_feature_begin     (conv_load_feature_begin),
		.return_req             (conv_return_req),
		.refresh_return_addr    (conv_refresh_return_addr),
		.compute_begin          (conv_compute_begin),
		.free_feature_read_addr (conv_free_feature_read_addr),
		.output_buffer_done     (conv_output_buffer_done)
	);

	pass_sequencer u_pass_sequencer (
		.system_clk             (system_clk),
		.rst_n                  (rst_n),
		.pass_go                (pass_go),
		.pass_order             (pass_order),
		.in_patches             (in_patches),
		.compute_finish         (compute_finish),
		.return_finish          (return_finish),
		.upsample_buffer_empty  (upsample_buffer_empty),
		.pass_done              (pass_done),
		.load_feature_begin     (pass_load_feature_begin),
		.return_req             (pass_return_req),
		.refresh_return_addr    (pass_refresh_return_addr),
		.compute_begin          (pass_compute_begin),
		.free_feature_read_addr (pass_free_feature_read_addr),
		.output_buffer_done     (pass_output_buffer_done)
	);

endmodule

`default_nettype wire

//--- rtl/pass_sequencer.sv
`default_nettype none

module pass_sequencer import acc_cmd_pkg::*, acc_fsm_pkg::*; (
	input  logic       system_clk,
	input  logic       rst_n,
	input  logic       pass_go,
	input  order_t     pass_order,
	input  patch_cnt_t in_patches,
	input  logic       compute_finish,
	input  logic       return_finish,
	input  logic       upsample_buffer_empty,
	output logic       pass_done,
	output logic       load_feature_begin,
	output logic       return_req,
	output logic       refresh_return_addr,
	output logic       compute_begin,
	output logic       free_feature_read_addr,
	output logic       output_buffer_done
);

	pass_state_e pass_state;
	patch_cnt_t  in_cnt;
	logic        add_mode;
	logic        drain_ok;
	logic        in_all;
	logic        finish;

	assign add_mode = (pass_order == ORDER_ADD);
	// upsample holds the return until its buffer is empty
	assign drain_ok = add_mode | (pass_order == ORDER_POOL) | upsample_buffer_empty;
	assign in_all   = (in_cnt == in_patches);
	assign finish   = (pass_state == PASS_CHECK_IN) && (add_mode || in_all);	// add is one pass

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			pass_state <= PASS_IDLE;
		end else begin
			case (pass_state)
				PASS_IDLE: begin
					if (pass_go) begin
						pass_state <= PASS_LOAD;
					end
				end
				PASS_LOAD: pass_state <= PASS_WAIT_CALC;
				PASS_WAIT_CALC: begin
					if (compute_finish) begin
						pass_state <= PASS_WAIT_RET;
					end
				end
				PASS_WAIT_RET: begin
					if (return_finish) begin
						pass_state <= PASS_CHECK_IN;
					end
				end
				PASS_CHECK_IN: pass_state <= finish ? PASS_DONE : PASS_LOAD;
				PASS_DONE: pass_state <= PASS_IDLE;
				default: pass_state <= PASS_IDLE;
			endcase
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			in_cnt <= '0;
		end else if ((pass_state == PASS_WAIT_RET) && return_finish) begin
			in_cnt <= in_cnt + 8'd1;
		end else if (pass_state == PASS_DONE) begin
			in_cnt <= '0;
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			load_feature_begin     <= 1'b0;
			return_req             <= 1'b0;
			refresh_return_addr    <= 1'b0;
			compute_begin          <= 1'b0;
			free_feature_read_addr <= 1'b0;
			output_buffer_done     <= 1'b0;
			pass_done              <= 1'b0;
		end else begin
			load_feature_begin  <= (pass_state == PASS_LOAD);
			return_req          <= (pass_state == PASS_LOAD);
			compute_begin       <= (pass_state == PASS_LOAD);
			refresh_return_addr <= (pass_state == PASS_LOAD) && (in_cnt == '0);	// first patch
			output_buffer_done  <= drain_ok &&
				(((pass_state == PASS_WAIT_CALC) && compute_finish) ||
				((pass_state == PASS_WAIT_RET) && !return_finish));
			free_feature_read_addr <= finish;
			pass_done              <= finish;
		end
	end

endmodule

`default_nettype wire

//--- rtl/conv_sequencer.sv
`default_nettype none

module conv_sequencer import acc_cmd_pkg::*, acc_fsm_pkg::*; (
	input  logic       system_clk,
	input  logic       rst_n,
	input  logic       conv_go,
	input  patch_cnt_t in_patches,
	input  patch_cnt_t out_patches,
	input  logic       weight_and_bias_ready,
	input  logic       compute_finish,
	input  logic       return_finish,
	output logic       conv_done,
	output wb_change_t change_weight_bias,
	output logic       direct_out,
	output logic       bias_or_adder_feature,
	output logic       load_feature_begin,
	output logic       return_req,
	output logic       refresh_return_addr,
	output logic       compute_begin,
	output logic       free_feature_read_addr,
	output logic       output_buffer_done
);

	conv_state_e conv_state;
	patch_cnt_t  in_cnt;
	patch_cnt_t  out_cnt;
	patch_cnt_t  last_in;
	logic        first_in;
	logic        in_last;
	logic        in_all;
	logic        out_all;

	assign last_in  = in_patches - 8'd1;
	assign first_in = (in_cnt == '0);
	assign in_last  = (in_cnt == last_in);	// this patch streams straight out
	assign in_all   = (in_cnt == in_patches);
	assign out_all  = (out_cnt == out_patches);

	// first input patch starts from bias, later ones accumulate
	assign bias_or_adder_feature = first_in;

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			conv_state <= CONV_IDLE;
		end else begin
			case (conv_state)
				CONV_IDLE: begin
					if (conv_go) begin
						conv_state <= CONV_SWAP_WB;
					end
				end
				CONV_SWAP_WB: conv_state <= CONV_WAIT_WB;
				CONV_WAIT_WB: begin
					if (weight_and_bias_ready) begin
						conv_state <= CONV_WAIT_CALC;
					end
				end
				CONV_WAIT_CALC: begin
					if (compute_finish) begin
						conv_state <= CONV_CHECK_IN;
					end
				end
				CONV_CHECK_IN: conv_state <= in_all ? CONV_WAIT_RET : CONV_SWAP_WB;
				CONV_WAIT_RET: begin
					if (return_finish) begin
						conv_state <= CONV_CHECK_OUT;
					end
				end
				CONV_CHECK_OUT: conv_state <= out_all ? CONV_DONE : CONV_SWAP_WB;
				CONV_DONE: conv_state <= CONV_IDLE;
				default: conv_state <= CONV_IDLE;
			endcase
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			in_cnt <= '0;
		end else if ((conv_state == CONV_WAIT_CALC) && compute_finish) begin
			in_cnt <= in_cnt + 8'd1;
		end else if (conv_state == CONV_WAIT_RET) begin
			in_cnt <= '0;
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			out_cnt <= '0;
		end else if ((conv_state == CONV_WAIT_RET) && return_finish) begin
			out_cnt <= out_cnt + 8'd1;
		end else if (conv_state == CONV_DONE) begin
			out_cnt <= '0;
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			change_weight_bias     <= '0;
			load_feature_begin     <= 1'b0;
			return_req             <= 1'b0;
			refresh_return_addr    <= 1'b0;
			compute_begin          <= 1'b0;
			free_feature_read_addr <= 1'b0;
			output_buffer_done     <= 1'b0;
			conv_done              <= 1'b0;
		end else begin
			change_weight_bias <= '0;
			if (conv_state == CONV_SWAP_WB) begin
				change_weight_bias <= first_in ? WB_FIRST : WB_NEXT;
			end
			load_feature_begin  <= (change_weight_bias != '0);
			return_req          <= (conv_state == CONV_SWAP_WB) && in_last;
			refresh_return_addr <= (conv_state == CONV_SWAP_WB) && in_last && (out_cnt == '0);
			compute_begin       <= (conv_state == CONV_WAIT_WB) && weight_and_bias_ready;
			free_feature_read_addr <= (conv_state == CONV_CHECK_IN) && in_all;
			// level for the whole return wait
			output_buffer_done <= ((conv_state == CONV_CHECK_IN) && in_all) ||
				((conv_state == CONV_WAIT_RET) && !return_finish);
			conv_done <= (conv_state == CONV_CHECK_OUT) && out_all;
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			direct_out <= 1'b0;
		end else if (conv_state == CONV_SWAP_WB) begin
			direct_out <= in_last;
		end else if (conv_state == CONV_DONE) begin
			direct_out <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/task_dispatch.sv
`default_nettype none

module task_dispatch import acc_cmd_pkg::*, acc_fsm_pkg::*; (
	input  logic       system_clk,
	input  logic       rst_n,
	input  logic       task_start,
	input  logic       task_finish,
	input  logic       calculate_start,
	input  order_t     order,
	input  patch_cnt_t in_patch_num,
	input  patch_cnt_t out_patch_num,
	input  logic       conv_done,
	input  logic       pass_done,
	input  wb_change_t conv_change_weight_bias,
	input  logic       conv_load_feature_begin,
	input  logic       conv_return_req,
	input  logic       conv_refresh_return_addr,
	input  logic       conv_compute_begin,
	input  logic       conv_free_feature_read_addr,
	input  logic       conv_output_buffer_done,
	input  logic       pass_load_feature_begin,
	input  logic       pass_return_req,
	input  logic       pass_refresh_return_addr,
	input  logic       pass_compute_begin,
	input  logic       pass_free_feature_read_addr,
	input  logic       pass_output_buffer_done,
	output logic       calculate_finish,
	output logic       conv_go,
	output logic       pass_go,
	output order_t     pass_order,
	output patch_cnt_t in_patches,
	output patch_cnt_t out_patches,
	output wb_change_t change_weight_bias,
	output logic       load_feature_begin,
	output logic       return_req,
	output logic       refresh_return_addr,
	output logic       compute_begin,
	output logic       free_feature_read_addr,
	output logic       output_buffer_done,
	output ret_sel_t   return_select,
	output kern_t      kernel_size
);

	task_state_e task_state;
	logic        order_known;
	logic        accept;
	logic        run_conv;
	logic        run_pass;

	assign order_known = (order == ORDER_CONV) | (order == ORDER_ADD) |
		(order == ORDER_POOL) | (order == ORDER_UPSAMPLE);
	assign accept = (task_state == TASK_WAIT_ORDER) & calculate_start & order_known;

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			task_state <= TASK_IDLE;
		end else begin
			case (task_state)
				TASK_IDLE: begin
					if (task_start) begin
						task_state <= TASK_WAIT_ORDER;
					end
				end
				TASK_WAIT_ORDER: begin
					if (accept) begin
						task_state <= (order == ORDER_CONV) ? TASK_CONV : TASK_PASS;
					end else if (task_finish) begin
						task_state <= TASK_IDLE;
					end
				end
				TASK_CONV: begin
					if (conv_done) begin
						task_state <= TASK_WAIT_ORDER;
					end
				end
				TASK_PASS: begin
					if (pass_done) begin
						task_state <= TASK_WAIT_ORDER;
					end
				end
				default: task_state <= TASK_IDLE;
			endcase
		end
	end

	// start pulses leave on the same edge as the state change
	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			conv_go <= 1'b0;
			pass_go <= 1'b0;
		end else begin
			conv_go <= accept & (order == ORDER_CONV);
			pass_go <= accept & (order != ORDER_CONV);
		end
	end

	always_ff @(posedge system_clk) begin
		if (accept) begin
			pass_order  <= order;
			in_patches  <= in_patch_num;
			out_patches <= out_patch_num;
		end
	end

	assign calculate_finish = (task_state == TASK_IDLE) | (task_state == TASK_WAIT_ORDER);

	// only one sequencer runs at a time
	assign change_weight_bias     = conv_change_weight_bias;
	assign load_feature_begin     = conv_load_feature_begin | pass_load_feature_begin;
	assign return_req             = conv_return_req | pass_return_req;
	assign refresh_return_addr    = conv_refresh_return_addr | pass_refresh_return_addr;
	assign compute_begin          = conv_compute_begin | pass_compute_begin;
	assign free_feature_read_addr = conv_free_feature_read_addr | pass_free_feature_read_addr;
	assign output_buffer_done     = conv_output_buffer_done | pass_output_buffer_done;

	assign run_conv = (task_state == TASK_CONV);
	assign run_pass = (task_state == TASK_PASS);

	assign return_select = {run_pass & (pass_order == ORDER_UPSAMPLE),
		run_pass & (pass_order == ORDER_POOL),
		run_pass & (pass_order == ORDER_ADD),
		run_conv};

	assign kernel_size = (run_pass & (pass_order == ORDER_POOL)) ? KERN_POOL : KERN_CONV;

endmodule

`default_nettype wire

//--- rtl/acc_fsm_pkg.sv
`default_nettype none

package acc_fsm_pkg;

	typedef enum logic [1:0] {
		TASK_IDLE,
		TASK_WAIT_ORDER,
		TASK_CONV,
		TASK_PASS
	} task_state_e;

	// nested loop, input patches inside output patches
	typedef enum logic [2:0] {
		CONV_IDLE,
		CONV_SWAP_WB,
		CONV_WAIT_WB,
		CONV_WAIT_CALC,
		CONV_CHECK_IN,
		CONV_WAIT_RET,
		CONV_CHECK_OUT,
		CONV_DONE
	} conv_state_e;

	// add, pool and upsample share this one
	typedef enum logic [2:0] {
		PASS_IDLE,
		PASS_LOAD,
		PASS_WAIT_CALC,
		PASS_WAIT_RET,
		PASS_CHECK_IN,
		PASS_DONE
	} pass_state_e;

endpackage

`default_nettype wire

//--- rtl/acc_cmd_pkg.sv
`default_nettype none

package acc_cmd_pkg;

	// order code as written by the host
	typedef logic [2:0] order_t;

	localparam order_t ORDER_CONV     = 3'd1;
	localparam order_t ORDER_ADD      = 3'd2;
	localparam order_t ORDER_POOL     = 3'd3;
	localparam order_t ORDER_UPSAMPLE = 3'd4;

	typedef logic [7:0] patch_cnt_t;

	// weight buffer swap request
	typedef logic [1:0] wb_change_t;

	localparam wb_change_t WB_FIRST = 2'b11;	// weights and bias
	localparam wb_change_t WB_NEXT  = 2'b01;	// weights only

	// one-hot return path, bit 0 conv .. bit 3 upsample
	typedef logic [3:0] ret_sel_t;

	// sliding window edge
	typedef logic [2:0] kern_t;

	localparam kern_t KERN_CONV = 3'd3;
	localparam kern_t KERN_POOL = 3'd5;

endpackage

`default_nettype wire
